/* logic/div_pkg.sv */
`default_nettype none

package div_pkg;

  localparam int DIVIDEND_W = 16;
  localparam int DIVISOR_W  = 8;
  localparam int COUNT_W    = 16;
  localparam int ERR_SUM_W  = 24;

  // low quotient rows built from the simplified cell
  localparam int APPROX_ROWS = 2;

  typedef logic [DIVIDEND_W-1:0] dividend_t;
  typedef logic [DIVISOR_W-1:0]  divisor_t;   // quotient and remainder too
  typedef logic [COUNT_W-1:0]    count_t;     // saturating
  typedef logic [ERR_SUM_W-1:0]  err_sum_t;   // saturating

  typedef struct packed {
    dividend_t n;
    divisor_t  d;
  } div_req_t;

  typedef struct packed {
    divisor_t q;         // approximate array
    divisor_t r;
    divisor_t q_exact;   // exact twin
    divisor_t r_exact;
    logic     ovf;       // quotient wider than 8 bits, or d is zero
  } div_res_t;

  typedef struct packed {
    count_t   total;
    count_t   mismatches;
    err_sum_t err_sum;   // sum of |q - q_exact|
  } div_stats_t;

endpackage

`default_nettype wire

/* logic/div_array.sv */
`timescale 1ns/100ps
`default_nettype none

module div_array #(
  parameter int approx_rows = div_pkg::APPROX_ROWS
) (
  input  div_pkg::dividend_t n,
  input  div_pkg::divisor_t  d,
  output div_pkg::divisor_t  q,
  output div_pkg::divisor_t  r
);

  import div_pkg::*;

  typedef struct packed {
    logic bout;
    logic diff;
  } cell_t;

  // full subtractor x - y - bin
  function automatic cell_t exact_cell(
    input logic x,
    input logic y,
    input logic bin
  );
    cell_t c;
    c.diff = x ^ y ^ bin;
    c.bout = (~x & y) | (~(x ^ y) & bin);
    return c;
  endfunction

  // simplified cell with the difference tied low and no borrow in
  function automatic cell_t approx_cell(
    input logic x,
    input logic y
  );
    cell_t c;
    c.diff = 1'b0;
    c.bout = x & y;
    return c;
  endfunction

  // non-performing restoring array with one row per quotient bit
  always_comb begin
    logic [DIVISOR_W:0] win;
    divisor_t           part;
    divisor_t           diff;
    logic               borrow;
    cell_t              c;

    q    = '0;
    part = n[DIVIDEND_W-1 -: DIVISOR_W];   // row 7 sees n[15:7]
    for (int k = DIVISOR_W - 1; k >= 0; k--) begin
      win    = {part, n[k]};
      borrow = 1'b0;
      diff   = '0;
      // borrow ripples from lsb to msb of the low 8 window bits
      for (int b = 0; b < DIVISOR_W; b++) begin
        if (k < approx_rows) begin
          c = approx_cell(win[b], d[b]);
        end else begin
          c = exact_cell(win[b], d[b], borrow);
        end
        diff[b] = c.diff;
        borrow  = c.bout;
      end
      // window top bit set means the subtraction cannot go negative
      q[k] = win[DIVISOR_W] | ~borrow;
      part = q[k] ? diff : win[DIVISOR_W-1:0];   // restore when no subtract
    end
    r = part;
  end

endmodule

`default_nettype wire

/* logic/div_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module div_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  output logic              in_ready,
  input  div_pkg::div_req_t in_req,
  output logic              out_valid,
  input  logic              out_ready,
  output div_pkg::div_res_t out_res
);

  import div_pkg::*;

  logic     started;   // low through reset and high from the first edge after
  logic     s1_valid;
  div_req_t s1_req;
  logic     s2_valid;
  div_res_t s2_res;
  logic     s1_load;
  logic     s2_load;
  div_res_t nxt_res;
  divisor_t q_apx;
  divisor_t r_apx;
  divisor_t q_ex;
  divisor_t r_ex;

  // s2 frees first and s1 follows it
  assign s2_load  = ~s2_valid | out_ready;
  assign s1_load  = ~s1_valid | s2_load;
  assign in_ready = s1_load & started;

  div_array #(
    .approx_rows(APPROX_ROWS)
  ) u_apx (
    .n (s1_req.n),
    .d (s1_req.d),
    .q (q_apx),
    .r (r_apx)
  );

  div_array #(
    .approx_rows(0)
  ) u_exact (
    .n (s1_req.n),
    .d (s1_req.d),
    .q (q_ex),
    .r (r_ex)
  );

  always_comb begin
    nxt_res.q       = q_apx;
    nxt_res.r       = r_apx;
    nxt_res.q_exact = q_ex;
    nxt_res.r_exact = r_ex;
    // a zero divisor also fails this compare
    nxt_res.ovf     = (s1_req.n[DIVIDEND_W-1 -: DIVISOR_W] >= s1_req.d);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started  <= 1'b0;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      started <= 1'b1;
      if (s1_load) begin
        s1_valid <= in_valid & in_ready;
      end
      if (s2_load) begin
        s2_valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      s1_req <= in_req;
    end
    if (s2_load && s1_valid) begin
      s2_res <= nxt_res;   // both arrays settle within the cycle
    end
  end

  assign out_valid = s2_valid;
  assign out_res   = s2_res;

endmodule

`default_nettype wire

/* logic/div_error_stats.sv */
`timescale 1ns/100ps
`default_nettype none

module div_error_stats (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                res_fire,
  input  div_pkg::div_res_t   res,
  input  logic                stats_clear,
  output div_pkg::div_stats_t stats
);

  import div_pkg::*;

  logic               take;       // accepted result inside the 8-bit range
  logic               mismatch;
  divisor_t           q_err;      // |q - q_exact|
  logic [ERR_SUM_W:0] err_acc;    // one spare bit to spot the wrap

  function automatic count_t sat_inc(input count_t v);
    return (v == '1) ? v : v + count_t'(1);
  endfunction

  assign take     = res_fire & ~res.ovf;
  assign mismatch = (res.q != res.q_exact) || (res.r != res.r_exact);
  assign q_err    = (res.q > res.q_exact) ? res.q - res.q_exact
                                          : res.q_exact - res.q;
  assign err_acc  = {1'b0, stats.err_sum} + (ERR_SUM_W + 1)'(q_err);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stats <= '0;
    end else if (stats_clear) begin
      stats <= '0;   // wins over a result in the same cycle
    end else if (take) begin
      stats.total <= sat_inc(stats.total);
      if (mismatch) begin
        stats.mismatches <= sat_inc(stats.mismatches);
      end
      stats.err_sum <= err_acc[ERR_SUM_W] ? '1 : err_acc[ERR_SUM_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* logic/div_top.sv */
`timescale 1ns/100ps
`default_nettype none

module div_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  output logic                in_ready,
  input  div_pkg::div_req_t   in_req,
  output logic                out_valid,
  input  logic                out_ready,
  output div_pkg::div_res_t   out_res,
  input  logic                stats_clear,
  output div_pkg::div_stats_t stats
);

  logic res_fire;   // result leaves the pipeline on this edge

  assign res_fire = out_valid & out_ready;

  div_unit u_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_res   (out_res)
  );

  // sees the same result word the consumer takes
  div_error_stats u_stats (
    .clk         (clk),
    .rst_n       (rst_n),
    .res_fire    (res_fire),
    .res         (out_res),
    .stats_clear (stats_clear),
    .stats       (stats)
  );

endmodule

`default_nettype wire

/* dv/div_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module div_checker (
  input logic              clk,
  input logic              rst_n,
  input logic              in_valid,
  input logic              in_ready,
  input logic              out_valid,
  input logic              out_ready,
  input div_pkg::div_res_t out_res
);

  // result word frozen while the consumer stalls
  a_out_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_res)
  ) else $error("out_valid or out_res changed while out_ready was low");

  a_reset_idle: assert property (
    @(posedge clk) !rst_n |-> !in_ready && !out_valid
  ) else $error("in_ready or out_valid high during reset");

  // two edges from acceptance to out_valid
  a_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid && in_ready ##1 out_ready |=> out_valid
  ) else $error("result missing two cycles after acceptance");

endmodule

bind div_unit div_checker u_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_res   (out_res)
);

`default_nettype wire

/* dv/div_model.svh */
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

// one subtractor cell, returns {borrow out, difference}
function automatic logic [1:0] cell_step(
  input logic approx,
  input logic x,
  input logic y,
  input logic bin
);
  int s;
  if (approx) begin
    return {x & y, 1'b0};   // simplified cell drops the difference
  end
  s = int'(x) - int'(y) - int'(bin);
  return {s < 0, s[0]};
endfunction

// restoring array, rows below depth use the simplified cell
// result is {quotient, remainder}
function automatic logic [15:0] array_divide(
  input dividend_t n,
  input divisor_t  d,
  input int        depth
);
  logic [8:0] win;
  divisor_t   rest;
  divisor_t   diff;
  divisor_t   q;
  logic [1:0] c;
  logic       b;
  rest = n[15:8];
  q    = '0;
  diff = '0;
  for (int k = 7; k >= 0; k--) begin
    win = {rest, n[k]};
    b   = 1'b0;
    for (int j = 0; j < 8; j++) begin
      c       = cell_step(k < depth, win[j], d[j], b);
      diff[j] = c[0];
      b       = c[1];
    end
    q[k] = win[8] | ~b;
    rest = q[k] ? diff : win[7:0];
  end
  return {q, rest};
endfunction

`endif

/* dv/div_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module div_tb;

  import div_pkg::*;

  `include "div_model.svh"

  localparam int WAIT_LIMIT = 200;

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  logic       in_ready;
  div_req_t   in_req;
  logic       out_valid;
  logic       out_ready = 1'b1;
  div_res_t   out_res;
  logic       stats_clear;
  div_stats_t stats;

  int         seed;
  int         bp_word;
  int         cycle = 0;
  logic       live = 1'b0;         // one edge past reset release
  logic       next_ready = 1'b1;
  logic       bp_mode;             // random stalls on the output
  logic       lat_check;           // out_ready held high, latency is fixed
  logic       passed;
  logic       fail_shown;
  div_req_t   req_q[$];
  int         acc_q[$];            // cycle of each acceptance
  count_t     exp_total;
  count_t     exp_mism;
  err_sum_t   exp_err;

  div_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_req      (in_req),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_res     (out_res),
    .stats_clear (stats_clear),
    .stats       (stats)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    live  <= rst_n;
  end

  // drawn at the falling edge, applied after the next rising edge
  always @(negedge clk) begin
    bp_word    = $random(seed);
    next_ready = bp_word[0];
  end

  always @(posedge clk) begin
    #1;
    out_ready = bp_mode ? next_ready : 1'b1;
  end

  task automatic value_error(input string what);
    $display("FAIL t=%0t %s", $time, what);
    fail_shown = 1'b1;
    $display("SOME TESTS FAILED");
    $fatal(1, "value check failed");
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    fail_shown = 1'b1;
    $display("SOME TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_result(input div_req_t req, input int acc);
    logic        ovf_exp;
    divisor_t    q_int;
    divisor_t    r_int;
    logic [15:0] qr_model;
    divisor_t    q_gap;
    ovf_exp = (req.d == '0) || (req.n[15:8] >= req.d);
    assert (out_res.ovf == ovf_exp)
      else value_error($sformatf("ovf got %0b for n=%0d d=%0d", out_res.ovf, req.n, req.d));
    if (lat_check) begin
      assert (cycle - acc == 2)
        else value_error($sformatf("latency got %0d cycles", cycle - acc));
    end
    if (!ovf_exp) begin
      q_int    = divisor_t'(req.n / {8'h00, req.d});
      r_int    = divisor_t'(req.n % {8'h00, req.d});
      qr_model = array_divide(req.n, req.d, APPROX_ROWS);
      assert (out_res.q_exact == q_int && out_res.r_exact == r_int)
        else value_error($sformatf("q_exact/r_exact got %0d/%0d expected %0d/%0d",
                                   out_res.q_exact, out_res.r_exact, q_int, r_int));
      assert (out_res.q == qr_model[15:8] && out_res.r == qr_model[7:0])
        else value_error($sformatf("q/r got %0d/%0d expected %0d/%0d", out_res.q,
                                   out_res.r, qr_model[15:8], qr_model[7:0]));
      q_gap = (qr_model[15:8] > q_int) ? qr_model[15:8] - q_int : q_int - qr_model[15:8];
      if (exp_total != '1) exp_total = exp_total + count_t'(1);
      if ((qr_model[15:8] != q_int || qr_model[7:0] != r_int) && exp_mism != '1) begin
        exp_mism = exp_mism + count_t'(1);
      end
      if (exp_err > err_sum_t'('1) - err_sum_t'(q_gap)) begin
        exp_err = '1;
      end else begin
        exp_err = exp_err + err_sum_t'(q_gap);
      end
    end
  endtask

  // handshake monitor, everything is stable at the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      assert (!in_ready && !out_valid) else value_error("handshake active in reset");
      assert (stats == '0) else value_error("stats not zero in reset");
    end else begin
      if (live && !in_ready) begin
        assert (req_q.size() == 2 && !out_ready)
          else value_error($sformatf("in_ready low with %0d in flight", req_q.size()));
      end
      if (out_valid && out_ready) begin
        if (req_q.size() == 0) begin
          abort_run("a result came out with no request pending");
        end
        check_result(req_q.pop_front(), acc_q.pop_front());
      end
      if (in_valid && in_ready) begin
        req_q.push_back(in_req);
        acc_q.push_back(cycle);
      end
    end
  end

  // starts and ends 1 ns after a rising edge, in_valid stays high
  task automatic send_req(input dividend_t n, input divisor_t d);
    int waited;
    waited   = 0;
    in_valid = 1'b1;
    in_req   = {n, d};
    @(negedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout waiting for in_ready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send_random(input logic allow_ovf);
    int       word;
    divisor_t d;
    divisor_t top;
    word = $random(seed);
    d    = word[7:0];
    top  = word[15:8];
    if (!allow_ovf) begin
      if (d == '0) d = 8'd1;
      top = top % d;   // keeps the quotient inside 8 bits
    end
    send_req({top, word[23:16]}, d);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (req_q.size() != 0) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout waiting for results to drain");
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_stats();
    assert (stats.total == exp_total)
      else value_error($sformatf("total got %0d expected %0d", stats.total, exp_total));
    assert (stats.mismatches == exp_mism)
      else value_error($sformatf("mismatches got %0d expected %0d",
                                 stats.mismatches, exp_mism));
    assert (stats.err_sum == exp_err)
      else value_error($sformatf("err_sum got %0d expected %0d", stats.err_sum, exp_err));
  endtask

  task automatic clear_stats();
    stats_clear = 1'b1;
    @(posedge clk);
    #1;
    stats_clear = 1'b0;
    assert (stats == '0) else value_error("stats not zero after stats_clear");
    exp_total = '0;
    exp_mism  = '0;
    exp_err   = '0;
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_req      = '0;
    stats_clear = 1'b0;
    seed        = 40;
    bp_mode     = 1'b0;
    lat_check   = 1'b0;
    passed      = 1'b0;
    fail_shown  = 1'b0;
    exp_total   = '0;
    exp_mism    = '0;
    exp_err     = '0;

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    @(negedge clk);
    assert (in_ready) else value_error("in_ready low in the first cycle after reset");
    @(posedge clk);
    #1;

    // full rate, directed corners then random in-range operands
    lat_check = 1'b1;
    send_req(16'h00C7, 8'd1);
    send_req(16'h0001, 8'd1);
    send_req(16'hFE12, 8'd255);
    send_req(16'h00FF, 8'd255);
    send_req(16'h0005, 8'd7);     // low rows restore
    send_req(16'h1E0D, 8'd31);
    send_req(16'h64C9, 8'd200);
    send_req(16'h1234, 8'd0);     // zero divisor
    send_req(16'h0A00, 8'd10);    // top byte equals d
    send_req(16'hFF00, 8'd1);
    repeat (40) send_random(1'b0);
    in_valid = 1'b0;
    wait_drain();
    check_stats();
    clear_stats();

    // random stalls, overflow mixed in
    lat_check = 1'b0;
    bp_mode   = 1'b1;
    for (int i = 0; i < 80; i++) begin
      send_random(i % 4 == 0);
    end
    in_valid = 1'b0;
    wait_drain();
    bp_mode = 1'b0;
    check_stats();
    clear_stats();

    passed = 1'b1;
    $display("ALL TESTS PASSED");
    $finish;
  end

  // run stopped by a bound assertion
  final begin
    if (!passed && !fail_shown) begin
      $display("SOME TESTS FAILED");
    end
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+dv
logic/div_pkg.sv
logic/div_array.sv
logic/div_unit.sv
logic/div_error_stats.sv
logic/div_top.sv
dv/div_checker.sv
dv/div_tb.sv

/* run.sh */
#!/bin/sh
# build and run the divider testbench, the log decides pass or fail
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module div_tb -f list.f -o div_sim &&
  { ./obj_dir/div_sim > sim.log 2>&1; cat sim.log; } &&
  grep -q "ALL TESTS PASSED" sim.log &&
  echo "run.sh: simulation passed" ||
  { echo "run.sh: simulation failed"; exit 1; }
